// File: glb_tile.f
+incdir+design
design/glb_cfg_pkg.sv
design/glb_dma_pkg.sv
design/glb_tile_cfg.sv
design/glb_store_dma_ctrl.sv
design/glb_store_addr_gen.sv
design/glb_bank.sv
design/glb_tile.sv
verif/glb_tile_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the glb_tile testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f glb_tile.f \
    --top-module glb_tile_tb -o glb_tile_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/glb_tile_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" sim.log; then
    exit 1
fi
if ! grep -q "Everything OK" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

// File: verif/glb_tile_tb.sv
`include "glb_consts.svh"

module glb_tile_tb
    import glb_cfg_pkg::*, glb_dma_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam tile_id_t  my_tile = 4'h5;
    localparam cfg_data_t east_offset = 32'h1000_0000;   // east model data = addr + offset

    logic        clk;
    logic        reset;
    tile_id_t    tile_id;
    logic        wr_clk_en;
    logic        rd_clk_en;
    cfg_wr_req_t wst_wr;
    cfg_rd_req_t wst_rd;
    cfg_rd_rsp_t wst_rsp;
    cfg_wr_req_t est_wr;
    cfg_rd_req_t est_rd;
    cfg_rd_rsp_t est_rsp;
    logic        stream_valid;
    data_word_t  stream_data;
    logic        mem_rd_en;
    glb_addr_t   mem_rd_addr;
    data_word_t  mem_rd_data;
    logic        mem_rd_data_valid;
    tile_id_t    multi_tile_size;
    logic        tile_is_start;
    logic        tile_is_end;

    cfg_data_t   shadow_reg [32];                      // reference register map
    data_word_t  shadow_mem [2**`GLB_ADDR_WIDTH];      // reference bank
    cfg_rd_rsp_t rsp_mask;                             // bits not compared on a read
    cfg_rd_rsp_t exp_rsp;
    cfg_wr_req_t exp_wr;
    cfg_rd_req_t exp_rd;
    cfg_rd_rsp_t exp_rsp_q;
    cfg_rd_rsp_t rsp_mask_q;
    cfg_wr_req_t exp_wr_q;
    cfg_rd_req_t exp_rd_q;
    data_word_t  exp_mem_q;
    logic        mem_rd_en_q;                          // bank read issued last cycle
    logic [5:0]  tile_q;
    int          seed = 32'h7a1d_cfee;
    int          rsp_errs = 0;
    int          fwd_errs = 0;
    int          cfg_errs = 0;
    int          mem_errs = 0;
    int          timeout_errs = 0;

    glb_tile DUT (.*);

    always #20 clk = ~clk;

    // east neighbour answers one cycle after a forwarded read
    always @(negedge clk) begin
        if (est_rd.rd_en) begin
            est_rsp = '{1'b1, cfg_data_t'(est_rd.rd_addr) + east_offset};
        end else begin
            est_rsp = '0;
        end
    end

    always_comb begin
        exp_rsp = est_rsp;
        exp_wr  = '0;
        exp_rd  = '0;
        if (wst_rd.rd_en && wst_rd.rd_addr[`GLB_CFG_TILE_LSB +: 4] == tile_id) begin
            exp_rsp.rd_data_valid = 1'b1;
            exp_rsp.rd_data       = shadow_reg[wst_rd.rd_addr[`GLB_CFG_REG_LSB +: 5]];
        end else if (wst_rd.rd_en) begin
            exp_rd = wst_rd;
        end
        if (wst_wr.wr_en && wst_wr.wr_addr[`GLB_CFG_TILE_LSB +: 4] != tile_id) begin
            exp_wr = wst_wr;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exp_rsp_q   <= '0;
            rsp_mask_q  <= '0;
            exp_wr_q    <= '0;
            exp_rd_q    <= '0;
            exp_mem_q   <= '0;
            mem_rd_en_q <= 1'b0;
            tile_q      <= '0;
        end else begin
            exp_rsp_q   <= exp_rsp;
            rsp_mask_q  <= rsp_mask;
            exp_wr_q    <= exp_wr;
            exp_rd_q    <= exp_rd;
            exp_mem_q   <= shadow_mem[mem_rd_addr];
            mem_rd_en_q <= mem_rd_en;
            tile_q      <= shadow_reg[0][5:0];
        end
    end

    a_reset: assert property (@(posedge clk) $fell(reset) |-> (wst_rsp == '0 && est_wr == '0
            && est_rd == '0 && multi_tile_size == '0 && !tile_is_start && !tile_is_end))
        else begin
            cfg_errs++;
            $display("[ERROR] %0t wst_rsp/est_wr/est_rd/tile outputs expected 0 got %h %h %h %h",
                     $time, $sampled(wst_rsp), $sampled(est_wr), $sampled(est_rd),
                     $sampled({tile_is_end, tile_is_start, multi_tile_size}));
        end

    a_rsp: assert property (@(posedge clk) disable iff (reset)
            ((wst_rsp ^ exp_rsp_q) & ~rsp_mask_q) == '0)
        else begin
            rsp_errs++;
            $display("[ERROR] %0t wst_rsp expected %h got %h", $time,
                     $sampled(exp_rsp_q), $sampled(wst_rsp));
        end

    a_est_wr: assert property (@(posedge clk) disable iff (reset) est_wr == exp_wr_q)
        else begin
            fwd_errs++;
            $display("[ERROR] %0t est_wr expected %h got %h", $time,
                     $sampled(exp_wr_q), $sampled(est_wr));
        end

    a_est_rd: assert property (@(posedge clk) disable iff (reset) est_rd == exp_rd_q)
        else begin
            fwd_errs++;
            $display("[ERROR] %0t est_rd expected %h got %h", $time,
                     $sampled(exp_rd_q), $sampled(est_rd));
        end

    a_tile: assert property (@(posedge clk) disable iff (reset)
            {tile_is_end, tile_is_start, multi_tile_size} == tile_q)
        else begin
            cfg_errs++;
            $display("[ERROR] %0t multi_tile outputs expected %h got %h", $time,
                     $sampled(tile_q), $sampled({tile_is_end, tile_is_start, multi_tile_size}));
        end

    a_mem_valid: assert property (@(posedge clk) disable iff (reset)
            mem_rd_data_valid == mem_rd_en_q)
        else begin
            mem_errs++;
            $display("[ERROR] %0t mem_rd_data_valid expected %b got %b", $time,
                     $sampled(mem_rd_en_q), $sampled(mem_rd_data_valid));
        end

    a_mem: assert property (@(posedge clk) disable iff (reset)
            mem_rd_data_valid |-> mem_rd_data == exp_mem_q)
        else begin
            mem_errs++;
            $display("[ERROR] %0t mem_rd_data expected %h got %h", $time,
                     $sampled(exp_mem_q), $sampled(mem_rd_data));
        end

    function automatic cfg_addr_t make_addr(tile_id_t t, int r);
        return {1'b0, t, r[4:0], 2'b00};
    endfunction

    task automatic finish_run();
        int total;
        total = rsp_errs + fwd_errs + cfg_errs + mem_errs + timeout_errs;
        $display("errors: rsp=%0d fwd=%0d cfg=%0d mem=%0d timeout=%0d",
                 rsp_errs, fwd_errs, cfg_errs, mem_errs, timeout_errs);
        if (total == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    task automatic cfg_write(tile_id_t t, int r, cfg_data_t d);
        @(negedge clk);
        wst_wr = '{1'b1, make_addr(t, r), d};
        if (t == tile_id) begin
            if (r == 0) shadow_reg[0] = d & 32'h3f;
            else if (r == 1) shadow_reg[1] = d & 32'h3;
            else if (r >= 2 && r <= 9 && r % 2 == 0) shadow_reg[r] = d & 32'hff;
            else if (r >= 2 && r <= 9) shadow_reg[r] = d & 32'h1fff;
        end
        @(negedge clk);
        wst_wr = '0;
    endtask

    task automatic cfg_read(tile_id_t t, int r, cfg_data_t mask, output cfg_data_t d);
        int tries;
        @(negedge clk);
        wst_rd   = '{1'b1, make_addr(t, r)};
        rsp_mask = '{1'b0, mask};
        @(negedge clk);
        wst_rd = '0;
        tries  = 0;
        while (!wst_rsp.rd_data_valid) begin
            if (tries == 8) begin
                timeout_errs++;
                $display("timeout: no read response from the west port");
                finish_run();
            end
            tries++;
            @(negedge clk);
        end
        d        = wst_rsp.rd_data;
        rsp_mask = '0;
    endtask

    // stream words are recorded in the bank model only when a header takes them
    task automatic send_words(int n, glb_addr_t start, bit record);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            stream_valid = 1'b1;
            stream_data  = data_word_t'($random(seed));
            if (record) shadow_mem[start + glb_addr_t'(i)] = stream_data;
        end
        @(negedge clk);
        stream_valid = 1'b0;
    endtask

    task automatic wait_retired(int q);
        cfg_data_t d;
        int tries;
        tries = 0;
        d     = 32'h1;
        while (d[0]) begin
            if (tries == 20) begin
                timeout_errs++;
                $display("timeout: header %0d never retired", q);
                finish_run();
            end
            tries++;
            cfg_read(tile_id, 3 + 2*q, 32'h1, d);   // valid bit may drop any cycle
        end
        shadow_reg[3 + 2*q][0] = 1'b0;
    endtask

    task automatic run_header(int q, glb_addr_t start, int n);
        cfg_write(tile_id, 2 + 2*q, n);
        cfg_write(tile_id, 3 + 2*q, {start, 1'b1});
        repeat (2) @(negedge clk);               // seek sees valid and then loads
        send_words(n, start, 1'b1);
        wait_retired(q);
    endtask

    task automatic check_region(glb_addr_t start, int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            mem_rd_en   = 1'b1;
            mem_rd_addr = start + glb_addr_t'(i);
        end
        @(negedge clk);
        mem_rd_en = 1'b0;
    endtask

    initial begin
        cfg_data_t d;
        int        r;
        tile_id_t  other;
        clk          = 0;
        reset        = 1;
        tile_id      = my_tile;
        wr_clk_en    = 1;
        rd_clk_en    = 1;
        wst_wr       = '0;
        wst_rd       = '0;
        est_rsp      = '0;
        rsp_mask     = '0;
        stream_valid = 0;
        stream_data  = '0;
        mem_rd_en    = 0;
        mem_rd_addr  = '0;
        foreach (shadow_reg[i]) shadow_reg[i] = '0;
        foreach (shadow_mem[i]) shadow_mem[i] = '0;
        repeat (3) @(negedge clk);
        reset = 0;

        // local register map with dma kept off and headers invalid
        for (int i = 0; i < 40; i++) begin
            r = ($random(seed) & 32'h7fff_ffff) % 12;
            d = $random(seed);
            if (r == 1) d = '0;
            if (r >= 3 && r % 2 == 1) d[0] = 1'b0;
            cfg_write(tile_id, r, d);
            cfg_read(tile_id, r, '0, d);
        end

        // other tiles are forwarded east and answered by the east model
        for (int i = 0; i < 20; i++) begin
            other = tile_id ^ tile_id_t'(1 + ($random(seed) & 32'h7fff_ffff) % 15);
            cfg_write(other, i % 32, $random(seed));
            cfg_read(other, (i * 7) % 32, '0, d);
        end

        // header 3 ends where header 2 starts
        cfg_write(tile_id, 1, 32'h1);
        run_header(0, 12'h100, 5);
        run_header(1, 12'h200, 4);
        run_header(2, 12'h306, 3);
        run_header(3, 12'h300, 6);
        send_words(4, '0, 1'b0);                 // halted so nothing lands at 0x306

        // repeat mode runs entry 0 again after it is validated anew
        cfg_write(tile_id, 1, 32'h0);
        cfg_write(tile_id, 1, 32'h3);
        send_words(3, '0, 1'b0);                 // entry 0 is invalid so the words are dropped
        run_header(0, 12'h100, 5);
        run_header(1, 12'h200, 0);               // empty headers retire without writing
        run_header(2, 12'h306, 0);
        run_header(3, 12'h300, 0);
        run_header(0, 12'h100, 5);               // pointer wrapped back to entry 0

        check_region(12'h100, 5);
        check_region(12'h200, 4);
        check_region(12'h300, 9);
        for (int q = 0; q < 4; q++) begin
            cfg_read(tile_id, 3 + 2*q, '0, d);   // every valid bit reads 0
        end
        repeat (3) @(negedge clk);
        finish_run();
    end

endmodule

// File: design/glb_tile.sv
`include "glb_consts.svh"

module glb_tile
    import glb_cfg_pkg::*, glb_dma_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  tile_id_t    tile_id,
    input  logic        wr_clk_en,
    input  logic        rd_clk_en,
    input  cfg_wr_req_t wst_wr,
    input  cfg_rd_req_t wst_rd,
    output cfg_rd_rsp_t wst_rsp,
    output cfg_wr_req_t est_wr,
    output cfg_rd_req_t est_rd,
    input  cfg_rd_rsp_t est_rsp,
    input  logic        stream_valid,
    input  data_word_t  stream_data,
    input  logic        mem_rd_en,
    input  glb_addr_t   mem_rd_addr,
    output data_word_t  mem_rd_data,
    output logic        mem_rd_data_valid,
    output tile_id_t    multi_tile_size,
    output logic        tile_is_start,
    output logic        tile_is_end
);

    dma_header_t                  headers [`GLB_QUEUE_DEPTH];
    logic [`GLB_QUEUE_DEPTH-1:0]  invalidate;
    logic                         dma_on;
    logic                         dma_auto_on;
    logic                         load;
    glb_addr_t                    hdr_start;
    num_words_t                   hdr_count;
    logic                         step;      // one accepted stream word
    logic                         last;
    glb_addr_t                    wr_addr;

    glb_tile_cfg u_cfg (
        .clk, .reset, .tile_id, .wr_clk_en, .rd_clk_en,
        .wst_wr, .wst_rd, .wst_rsp, .est_wr, .est_rd, .est_rsp,
        .multi_tile_size, .tile_is_start, .tile_is_end,
        .dma_on, .dma_auto_on, .headers, .invalidate
    );

    glb_store_dma_ctrl u_ctrl (
        .clk, .reset, .dma_on, .dma_auto_on, .headers, .invalidate,
        .stream_valid, .load, .hdr_start, .hdr_count, .step, .last
    );

    glb_store_addr_gen u_addr_gen (
        .clk, .reset, .load, .start_addr(hdr_start), .count(hdr_count),
        .step, .addr(wr_addr), .last
    );

    glb_bank u_bank (
        .clk, .reset, .wr_en(step), .wr_addr, .wr_data(stream_data),
        .rd_en(mem_rd_en), .rd_addr(mem_rd_addr),
        .rd_data(mem_rd_data), .rd_data_valid(mem_rd_data_valid)
    );

endmodule

// File: design/glb_bank.sv
module glb_bank
    import glb_dma_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       wr_en,
    input  glb_addr_t  wr_addr,
    input  data_word_t wr_data,
    input  logic       rd_en,
    input  glb_addr_t  rd_addr,
    output data_word_t rd_data,
    output logic       rd_data_valid
);

    data_word_t mem [2**$bits(glb_addr_t)];

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_addr] <= wr_data;
        if (rd_en) rd_data <= mem[rd_addr];   // old data on same-address write
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_data_valid <= 1'b0;
        end else begin
            rd_data_valid <= rd_en;
        end
    end

endmodule

// File: design/glb_store_addr_gen.sv
module glb_store_addr_gen
    import glb_dma_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       load,
    input  glb_addr_t  start_addr,
    input  num_words_t count,
    input  logic       step,
    output glb_addr_t  addr,
    output logic       last
);

    num_words_t remaining;   // words left in the active header

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            addr <= '0;
        end else if (load) begin
            addr <= start_addr;
        end else if (step) begin
            addr <= addr + 1'b1;   // wraps at the top of the bank
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            remaining <= '0;
        end else if (load) begin
            remaining <= count;
        end else if (step && (remaining != '0)) begin
            remaining <= remaining - 1'b1;
        end
    end

    // the controller leaves stream on the step that sees last
    assign last = (remaining == num_words_t'(1));

endmodule

// File: design/glb_store_dma_ctrl.sv
`include "glb_consts.svh"

module glb_store_dma_ctrl
    import glb_dma_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        dma_on,
    input  logic        dma_auto_on,
    input  dma_header_t headers [`GLB_QUEUE_DEPTH],
    output logic [`GLB_QUEUE_DEPTH-1:0] invalidate,
    input  logic        stream_valid,
    output logic        load,
    output glb_addr_t   hdr_start,
    output num_words_t  hdr_count,
    output logic        step,
    input  logic        last
);

    localparam int ptr_width = $clog2(`GLB_QUEUE_DEPTH);
    localparam logic [ptr_width-1:0] last_ptr = ptr_width'(`GLB_QUEUE_DEPTH - 1);

    dma_state_e           state;
    dma_state_e           state_nxt;
    logic [ptr_width-1:0] ptr;       // queue pointer
    logic [ptr_width-1:0] ptr_nxt;
    dma_header_t          cur_hdr;

    assign cur_hdr = headers[ptr];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= dma_idle;
            ptr   <= '0;
        end else begin
            state <= state_nxt;
            ptr   <= ptr_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        ptr_nxt   = ptr;
        case (state)
            dma_idle: begin
                if (dma_on) state_nxt = dma_seek;
            end
            dma_seek: begin
                if (!dma_on) begin
                    state_nxt = dma_idle;   // only stops between headers
                    ptr_nxt   = '0;
                end else if (cur_hdr.valid) begin
                    // empty header is retired without writing
                    state_nxt = (cur_hdr.num_words == '0) ? dma_retire : dma_stream;
                end
            end
            dma_stream: begin
                if (stream_valid && last) state_nxt = dma_retire;
            end
            dma_retire: begin
                if (!cur_hdr.valid) begin
                    if (ptr != last_ptr) begin
                        ptr_nxt   = ptr + 1'b1;
                        state_nxt = dma_seek;
                    end else if (dma_auto_on) begin
                        ptr_nxt   = '0;   // wrap for repeat
                        state_nxt = dma_seek;
                    end else begin
                        state_nxt = dma_halt;
                    end
                end
            end
            dma_halt: begin
                if (!dma_on) begin
                    state_nxt = dma_idle;
                    ptr_nxt   = '0;
                end
            end
            default: state_nxt = dma_idle;
        endcase
    end

    // held until the register block shows valid low
    always_comb begin
        invalidate = '0;
        if (state == dma_retire) invalidate[ptr] = 1'b1;
    end

    assign load = (state == dma_seek) && dma_on && cur_hdr.valid && (cur_hdr.num_words != '0);
    assign hdr_start = cur_hdr.start_addr;
    assign hdr_count = cur_hdr.num_words;
    assign step      = (state == dma_stream) && stream_valid;   // words outside stream dropped

endmodule

// File: design/glb_tile_cfg.sv
`include "glb_consts.svh"

module glb_tile_cfg
    import glb_cfg_pkg::*, glb_dma_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  tile_id_t    tile_id,
    input  logic        wr_clk_en,
    input  logic        rd_clk_en,

    input  cfg_wr_req_t wst_wr,
    input  cfg_rd_req_t wst_rd,
    output cfg_rd_rsp_t wst_rsp,
    output cfg_wr_req_t est_wr,
    output cfg_rd_req_t est_rd,
    input  cfg_rd_rsp_t est_rsp,

    output tile_id_t    multi_tile_size,
    output logic        tile_is_start,
    output logic        tile_is_end,
    output logic        dma_on,
    output logic        dma_auto_on,
    output dma_header_t headers [`GLB_QUEUE_DEPTH],
    input  logic [`GLB_QUEUE_DEPTH-1:0] invalidate
);

    tile_id_t  wr_tile;
    reg_sel_t  wr_reg;
    tile_id_t  rd_tile;
    reg_sel_t  rd_reg;
    logic      wr_match;
    logic      rd_match;
    cfg_data_t rd_data_int;

    assign wr_tile = wst_wr.wr_addr[`GLB_CFG_TILE_LSB +: `GLB_TILE_SEL_WIDTH];
    assign wr_reg  = wst_wr.wr_addr[`GLB_CFG_REG_LSB +: `GLB_REG_SEL_WIDTH];
    assign rd_tile = wst_rd.rd_addr[`GLB_CFG_TILE_LSB +: `GLB_TILE_SEL_WIDTH];
    assign rd_reg  = wst_rd.rd_addr[`GLB_CFG_REG_LSB +: `GLB_REG_SEL_WIDTH];

    assign wr_match = wst_wr.wr_en && (wr_tile == tile_id);
    assign rd_match = wst_rd.rd_en && (rd_tile == tile_id);

    // register map writes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            multi_tile_size <= '0;
            tile_is_start   <= 1'b0;
            tile_is_end     <= 1'b0;
            dma_on          <= 1'b0;
            dma_auto_on     <= 1'b0;
            for (int q = 0; q < `GLB_QUEUE_DEPTH; q++) begin
                headers[q] <= '0;
            end
        end else if (wr_clk_en) begin
            if (wr_match) begin
                if (wr_reg == reg_sel_t'(`GLB_REG_TILE_CTRL)) begin
                    {tile_is_end, tile_is_start, multi_tile_size} <=
                        wst_wr.wr_data[`GLB_TILE_SEL_WIDTH+1:0];
                end
                if (wr_reg == reg_sel_t'(`GLB_REG_DMA_CTRL)) begin
                    {dma_auto_on, dma_on} <= wst_wr.wr_data[1:0];
                end
                for (int q = 0; q < `GLB_QUEUE_DEPTH; q++) begin
                    if (wr_reg == reg_sel_t'(`GLB_REG_HDR_BASE + 2*q)) begin
                        headers[q].num_words <= wst_wr.wr_data[`GLB_NUM_WORDS_WIDTH-1:0];
                    end
                    if (wr_reg == reg_sel_t'(`GLB_REG_HDR_BASE + 2*q + 1)) begin
                        {headers[q].start_addr, headers[q].valid} <=
                            wst_wr.wr_data[`GLB_ADDR_WIDTH:0];
                    end
                end
            end else begin
                // a local write wins over retirement, the controller keeps asking
                for (int q = 0; q < `GLB_QUEUE_DEPTH; q++) begin
                    if (invalidate[q]) begin
                        headers[q].valid <= 1'b0;
                    end
                end
            end
        end
    end

    // readback mux, unused indices read as zero
    always_comb begin
        rd_data_int = '0;
        if (rd_match) begin
            if (rd_reg == reg_sel_t'(`GLB_REG_TILE_CTRL)) begin
                rd_data_int = cfg_data_t'({tile_is_end, tile_is_start, multi_tile_size});
            end
            if (rd_reg == reg_sel_t'(`GLB_REG_DMA_CTRL)) begin
                rd_data_int = cfg_data_t'({dma_auto_on, dma_on});
            end
            for (int q = 0; q < `GLB_QUEUE_DEPTH; q++) begin
                if (rd_reg == reg_sel_t'(`GLB_REG_HDR_BASE + 2*q)) begin
                    rd_data_int = cfg_data_t'(headers[q].num_words);
                end
                if (rd_reg == reg_sel_t'(`GLB_REG_HDR_BASE + 2*q + 1)) begin
                    rd_data_int = cfg_data_t'({headers[q].start_addr, headers[q].valid});
                end
            end
        end
    end

    // writes for other tiles go east one cycle later
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            est_wr <= '0;
        end else if (wr_clk_en) begin
            if (wst_wr.wr_en && !wr_match) begin
                est_wr <= wst_wr;
            end else begin
                est_wr <= '0;   // idle or consumed here
            end
        end
    end

    // reads for other tiles go east one cycle later
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            est_rd <= '0;
        end else if (rd_clk_en) begin
            if (wst_rd.rd_en && !rd_match) begin
                est_rd <= wst_rd;
            end else begin
                est_rd <= '0;
            end
        end
    end

    // west response, local data or the registered east response
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wst_rsp <= '0;
        end else if (rd_clk_en) begin
            if (rd_match) begin
                wst_rsp.rd_data_valid <= 1'b1;
                wst_rsp.rd_data       <= rd_data_int;
            end else begin
                wst_rsp <= est_rsp;
            end
        end
    end

endmodule

// File: design/glb_dma_pkg.sv
`include "glb_consts.svh"

package glb_dma_pkg;

    typedef logic [`GLB_ADDR_WIDTH-1:0]      glb_addr_t;   // bank word address
    typedef logic [`GLB_NUM_WORDS_WIDTH-1:0] num_words_t;  // words per header
    typedef logic [`GLB_DATA_WIDTH-1:0]      data_word_t;  // stream and bank word

    // one store header of the queue
    typedef struct packed {
        logic       valid;
        glb_addr_t  start_addr;
        num_words_t num_words;
    } dma_header_t;

    // store controller states
    typedef enum logic [2:0] {
        dma_idle,     // dma off
        dma_seek,     // waiting for the header at the queue pointer
        dma_stream,   // writing stream words
        dma_retire,   // clearing the header valid bit
        dma_halt      // queue done, waiting for dma off
    } dma_state_e;

    // the controller keeps its own copy of the queue pointer
    // alongside the state, see glb_store_dma_ctrl

endpackage

// File: design/glb_cfg_pkg.sv
`include "glb_consts.svh"

package glb_cfg_pkg;

    typedef logic [`GLB_TILE_SEL_WIDTH-1:0] tile_id_t;   // tile field of a cfg address
    typedef logic [`GLB_REG_SEL_WIDTH-1:0]  reg_sel_t;   // register field of a cfg address
    typedef logic [`GLB_CFG_ADDR_WIDTH-1:0] cfg_addr_t;
    typedef logic [`GLB_CFG_DATA_WIDTH-1:0] cfg_data_t;

    // write side of a configuration port
    typedef struct packed {
        logic      wr_en;
        cfg_addr_t wr_addr;
        cfg_data_t wr_data;
    } cfg_wr_req_t;

    // read request, travels toward the owning tile
    typedef struct packed {
        logic      rd_en;
        cfg_addr_t rd_addr;
    } cfg_rd_req_t;

    // read response, travels back toward the west edge
    typedef struct packed {
        logic      rd_data_valid;
        cfg_data_t rd_data;
    } cfg_rd_rsp_t;

endpackage

// File: design/glb_consts.svh
`ifndef GLB_CONSTS_SVH
`define GLB_CONSTS_SVH

// configuration address fields
`define GLB_TILE_SEL_WIDTH   4
`define GLB_REG_SEL_WIDTH    5
`define GLB_CFG_REG_LSB      2    // register index starts at byte address bit 2
`define GLB_CFG_TILE_LSB     7    // tile id sits above the register index
`define GLB_CFG_ADDR_WIDTH   12
`define GLB_CFG_DATA_WIDTH   32

// bank and stream
`define GLB_ADDR_WIDTH       12
`define GLB_NUM_WORDS_WIDTH  8
`define GLB_DATA_WIDTH       16

// store header queue
`define GLB_QUEUE_DEPTH      4

// register map, header q uses indices base+2q and base+2q+1
`define GLB_REG_TILE_CTRL    0
`define GLB_REG_DMA_CTRL     1
`define GLB_REG_HDR_BASE     2

`endif
